//--- rtl/mipsCore_macros.svh
`ifndef MIPSCORE_MACROS_SVH
`define MIPSCORE_MACROS_SVH

// Instruction memory, 32-bit words
`define IMEM_WORDS 256
`define IMEM_AW    8     // Word index width of program port

// Data memory, 32-bit words
`define DMEM_WORDS 256
`define DMEM_AW    8

// IO window: address bits 31..10 all ones
`define IO_BASE    22'h3F_FFFF

// Word offsets inside the IO window
`define IO_SWITCH_OFS 8'd0
`define IO_LED_OFS    8'd1

`endif

//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeE;

    // Function field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functE;

    // Final ALU operation, resolved in decode
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpE;

    typedef struct packed {
        logic  regDst;    // Write rd instead of rt
        logic  aluSrc;    // Immediate as operand B
        logic  memToReg;
        logic  regWrite;
        logic  memWrite;
        logic  branch;
        logic  jump;
        aluOpE aluOp;
    } ctrlT;

endpackage

`default_nettype wire

//--- rtl/decodeIf.sv
`timescale 1ns/100ps
`default_nettype none

interface decodeIf import mipsPkg::*; ();

    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] immExt;    // Sign extended immediate
    logic [31:0] pcPlus4;
    ctrlT        ctrl;

    modport source (output rsData, rtData, immExt, pcPlus4, ctrl);

    modport sink (input rsData, rtData, immExt, pcPlus4, ctrl);

endinterface

`default_nettype wire

//--- rtl/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_macros.svh"

module fetchStage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run_i,
    // Program port
    input  logic                progWe_i,
    input  logic [`IMEM_AW-1:0] progAddr_i,
    input  logic [31:0]         progData_i,
    // Redirect from execute
    input  logic                branch_i,
    input  logic                jump_i,
    input  logic                aluZero_i,
    input  logic [31:0]         branchTarget_i,
    output logic [31:0]         instr_o,
    output logic [31:0]         pcPlus4_o
);

    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] jumpTarget;
    logic [31:0] imem [`IMEM_WORDS];

    ////////////////////////////////////////
    // Instruction memory
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (progWe_i) begin
            imem[progAddr_i] <= progData_i;
        end
    end

    assign instr_o = imem[pc[`IMEM_AW+1:2]];   // Word addressed, async read

    ////////////////////////////////////////
    // Next PC
    ////////////////////////////////////////

    assign pcPlus4_o  = pc + 32'd4;
    assign jumpTarget = {pcPlus4_o[31:28], instr_o[25:0], 2'b00};

    always_comb begin
        if (jump_i) begin
            nextPc = jumpTarget;
        end else if (branch_i && aluZero_i) begin
            nextPc = branchTarget_i;   // Taken beq
        end else begin
            nextPc = pcPlus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= 32'd0;
        end else if (run_i) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pcPlus4_i,
    input  logic [31:0] wbData_i,
    decodeIf.source     decOut
);

    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [4:0]  rdAddr;
    logic [4:0]  destAddr;
    logic        regWe;
    opcodeE      opcode;
    functE       funct;
    ctrlT        ctrl;
    logic [31:0] regs [32];

    assign rsAddr = instr_i[25:21];
    assign rtAddr = instr_i[20:16];
    assign rdAddr = instr_i[15:11];
    assign opcode = opcodeE'(instr_i[31:26]);
    assign funct  = functE'(instr_i[5:0]);

    ////////////////////////////////////////
    // Main control
    ////////////////////////////////////////

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl.regWrite = 1'b0;   // Unsupported funct acts as nop
                endcase
            end
            OP_ADDI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;   // Zero flag on equal
            end
            OP_J:    ctrl.jump = 1'b1;
            default: ;   // Unknown opcode acts as nop
        endcase
    end

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    assign destAddr = ctrl.regDst ? rdAddr : rtAddr;
    // No writes while halted or in reset, r0 stays zero
    assign regWe    = ctrl.regWrite && run_i && rst_n && (destAddr != 5'd0);

    always_ff @(posedge clk) begin
        if (regWe) begin
            regs[destAddr] <= wbData_i;
        end
    end

    assign decOut.rsData  = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign decOut.rtData  = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];
    assign decOut.immExt  = {{16{instr_i[15]}}, instr_i[15:0]};
    assign decOut.pcPlus4 = pcPlus4_i;
    assign decOut.ctrl    = ctrl;

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage import mipsPkg::*; (
    decodeIf.sink       decIn,
    output logic [31:0] aluResult_o,
    output logic        aluZero_o,
    output logic [31:0] branchTarget_o
);

    logic [31:0] opA;
    logic [31:0] opB;

    assign opA = decIn.rsData;
    assign opB = decIn.ctrl.aluSrc ? decIn.immExt : decIn.rtData;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (decIn.ctrl.aluOp)
            ALU_ADD: aluResult_o = opA + opB;
            ALU_SUB: aluResult_o = opA - opB;
            ALU_AND: aluResult_o = opA & opB;
            ALU_OR:  aluResult_o = opA | opB;
            ALU_SLT: aluResult_o = {31'd0, $signed(opA) < $signed(opB)};
            default: aluResult_o = 32'd0;
        endcase
    end

    assign aluZero_o = (aluResult_o == 32'd0);

    // Branch offset counts words relative to PC+4
    assign branchTarget_o = decIn.pcPlus4 + {decIn.immExt[29:0], 2'b00};

endmodule

`default_nettype wire

//--- rtl/memIoStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_macros.svh"

module memIoStage (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run_i,
    input  logic [15:0] switch_i,
    input  logic [31:0] aluResult_i,
    decodeIf.sink       decIn,
    output logic [31:0] wbData_o,
    output logic [15:0] led_o,
    output logic        ledStrobe_o
);

    logic                isIo;
    logic [7:0]          ioOfs;
    logic [`DMEM_AW-1:0] dmemAddr;
    logic                storeEn;
    logic                dmemWe;
    logic                ledWe;
    logic [31:0]         loadData;
    logic [31:0]         dmem [`DMEM_WORDS];

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    assign isIo     = (aluResult_i[31:10] == `IO_BASE);
    assign ioOfs    = aluResult_i[9:2];
    assign dmemAddr = aluResult_i[`DMEM_AW+1:2];

    assign storeEn = decIn.ctrl.memWrite && run_i && rst_n;
    assign dmemWe  = storeEn && !isIo;
    assign ledWe   = storeEn && isIo && (ioOfs == `IO_LED_OFS);

    always_ff @(posedge clk) begin
        if (dmemWe) begin
            dmem[dmemAddr] <= decIn.rtData;
        end
    end

    // LED port and its one-cycle strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led_o       <= 16'd0;
            ledStrobe_o <= 1'b0;
        end else begin
            ledStrobe_o <= ledWe;
            if (ledWe) begin
                led_o <= decIn.rtData[15:0];
            end
        end
    end

    ////////////////////////////////////////
    // Load path and write-back select
    ////////////////////////////////////////

    always_comb begin
        if (!isIo) begin
            loadData = dmem[dmemAddr];
        end else if (ioOfs == `IO_SWITCH_OFS) begin
            loadData = {16'd0, switch_i};   // Zero extended
        end else if (ioOfs == `IO_LED_OFS) begin
            loadData = {16'd0, led_o};      // LED readback
        end else begin
            loadData = 32'd0;
        end
    end

    assign wbData_o = decIn.ctrl.memToReg ? loadData : aluResult_i;

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_macros.svh"

module mipsCore (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run_i,
    input  logic                progWe_i,
    input  logic [`IMEM_AW-1:0] progAddr_i,
    input  logic [31:0]         progData_i,
    input  logic [15:0]         switch_i,
    output logic [15:0]         led_o,
    output logic                ledStrobe_o
);

    logic [31:0] instr;
    logic [31:0] pcPlus4;
    logic [31:0] aluResult;
    logic        aluZero;
    logic [31:0] branchTarget;
    logic [31:0] wbData;

    decodeIf decBus ();   // Decode to execute and memory

    fetchStage i_fetchStage (
        .clk           (clk),
        .rst_n         (rst_n),
        .run_i         (run_i),
        .progWe_i      (progWe_i),
        .progAddr_i    (progAddr_i),
        .progData_i    (progData_i),
        .branch_i      (decBus.ctrl.branch),
        .jump_i        (decBus.ctrl.jump),
        .aluZero_i     (aluZero),
        .branchTarget_i(branchTarget),
        .instr_o       (instr),
        .pcPlus4_o     (pcPlus4)
    );

    decodeStage i_decodeStage (
        .clk      (clk),
        .rst_n    (rst_n),
        .run_i    (run_i),
        .instr_i  (instr),
        .pcPlus4_i(pcPlus4),
        .wbData_i (wbData),
        .decOut   (decBus.source)
    );

    executeStage i_executeStage (
        .decIn         (decBus.sink),
        .aluResult_o   (aluResult),
        .aluZero_o     (aluZero),
        .branchTarget_o(branchTarget)
    );

    memIoStage i_memIoStage (
        .clk        (clk),
        .rst_n      (rst_n),
        .run_i      (run_i),
        .switch_i   (switch_i),
        .aluResult_i(aluResult),
        .decIn      (decBus.sink),
        .wbData_o   (wbData),
        .led_o      (led_o),
        .ledStrobe_o(ledStrobe_o)
    );

endmodule

`default_nettype wire

//--- bench/ledChecker.sv
`timescale 1ns/100ps
`default_nettype none

module ledChecker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run_i,
    input  logic [15:0] switch_i,
    input  logic [15:0] led_i,
    input  logic        ledStrobe_i,
    output int          errCount_o,
    output int          strobeCount_o
);

    localparam int STROBE_GAP = 11;   // One loop of retired instructions

    int          cycle;
    int          lastStrobe;
    logic [15:0] expected;

    // LED value the test program produces for switch value s
    function automatic logic [15:0] expectedLed(input logic [15:0] sw);
        logic [31:0] s;
        logic [31:0] twice;
        logic [31:0] sum;
        s     = {16'd0, sw};
        twice = s << 1;
        sum   = (twice | s) + ((s < twice) ? 32'd1 : 32'd0);
        return sum[15:0];
    endfunction

    initial begin
        errCount_o    = 0;
        strobeCount_o = 0;
        cycle         = 0;
        lastStrobe    = 0;
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!run_i || !rst_n) begin
            if (ledStrobe_i !== 1'b0) begin
                $display("LED strobe seen while the core is halted or in reset");
                errCount_o = errCount_o + 1;
            end
            if (led_i !== 16'h0000) begin
                $display("ERR led_o: expected %h, got %h", 16'h0000, led_i);
                errCount_o = errCount_o + 1;
            end
        end else if (ledStrobe_i === 1'b1) begin
            expected = expectedLed(switch_i);
            if (led_i !== expected) begin
                $display("ERR led_o: expected %h, got %h (switch_i %h)",
                         expected, led_i, switch_i);
                errCount_o = errCount_o + 1;
                if (led_i === 16'hDEAD) begin
                    $display("LED written from the slot that the beq should skip");
                end
            end
            if (strobeCount_o > 0 && cycle - lastStrobe != STROBE_GAP) begin
                $display("LED strobes came %0d cycles apart instead of %0d",
                         cycle - lastStrobe, STROBE_GAP);
                errCount_o = errCount_o + 1;
            end
            lastStrobe    = cycle;
            strobeCount_o = strobeCount_o + 1;
        end
    end

endmodule

`default_nettype wire

//--- bench/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_macros.svh"

module mipsCoreTb import mipsPkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int PROG_WORDS   = 13;
    localparam int LOOP_LEN     = 11;   // Instructions retired per loop
    localparam int ITERATIONS   = 20;
    localparam int TIMEOUT      = RESET_CYCLES + PROG_WORDS + 1 + ITERATIONS * LOOP_LEN + 100;

    localparam logic [15:0] SWITCH_ADDR = 16'hFC00;   // Sign extends into the IO window
    localparam logic [15:0] LED_ADDR    = 16'hFC04;
    localparam logic [15:0] DATA_ADDR   = 16'h0010;   // Data word 4

    logic                clk = 1'b0;
    logic                rst_n;
    logic                run;
    logic                progWe;
    logic [`IMEM_AW-1:0] progAddr;
    logic [31:0]         progData;
    logic [15:0]         switchVal;
    logic [15:0]         led;
    logic                ledStrobe;
    integer              seed;
    logic [31:0]         rnd;
    int                  cycles = 0;
    int                  chkErrors;
    int                  strobes;
    int                  errors;
    logic [31:0]         progImage [PROG_WORDS];

    always #4 clk = ~clk;

    mipsCore i_mipsCore (
        .clk        (clk),
        .rst_n      (rst_n),
        .run_i      (run),
        .progWe_i   (progWe),
        .progAddr_i (progAddr),
        .progData_i (progData),
        .switch_i   (switchVal),
        .led_o      (led),
        .ledStrobe_o(ledStrobe)
    );

    ledChecker i_ledChecker (
        .clk          (clk),
        .rst_n        (rst_n),
        .run_i        (run),
        .switch_i     (switchVal),
        .led_i        (led),
        .ledStrobe_i  (ledStrobe),
        .errCount_o   (chkErrors),
        .strobeCount_o(strobes)
    );

    function automatic logic [31:0] encodeR(functE fn, logic [4:0] rd, logic [4:0] rs,
                                            logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(opcodeE op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    ////////////////////////////////////////
    // Test program
    ////////////////////////////////////////

    task automatic buildProgram();
        progImage[0]  = encodeI(OP_ADDI, 5'd0, 5'd9, 16'hDEAD);   // Marker, outside the loop
        progImage[1]  = encodeI(OP_LW, 5'd0, 5'd1, SWITCH_ADDR);
        progImage[2]  = encodeR(FN_ADD, 5'd2, 5'd1, 5'd1);
        progImage[3]  = encodeI(OP_SW, 5'd0, 5'd2, DATA_ADDR);
        progImage[4]  = encodeI(OP_LW, 5'd0, 5'd3, DATA_ADDR);
        progImage[5]  = encodeR(FN_SUB, 5'd4, 5'd3, 5'd1);
        progImage[6]  = encodeR(FN_OR, 5'd5, 5'd4, 5'd2);
        progImage[7]  = encodeR(FN_SLT, 5'd6, 5'd1, 5'd2);
        progImage[8]  = encodeR(FN_ADD, 5'd7, 5'd5, 5'd6);
        progImage[9]  = encodeI(OP_SW, 5'd0, 5'd7, LED_ADDR);
        progImage[10] = encodeI(OP_BEQ, 5'd0, 5'd0, 16'h0001);    // Always taken
        progImage[11] = encodeI(OP_SW, 5'd0, 5'd9, LED_ADDR);     // Must be skipped
        progImage[12] = {OP_J, 26'd1};                            // Back to the lw
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = 32'd0;
        switchVal = 16'd0;
        seed      = 32'h8883;
        buildProgram();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int k = 0; k < PROG_WORDS; k++) begin
            progWe   = 1'b1;
            progAddr = k[`IMEM_AW-1:0];
            progData = progImage[k];
            @(posedge clk);
            #1;
        end
        progWe    = 1'b0;
        rnd       = $random(seed);
        switchVal = rnd[15:0];
        run       = 1'b1;

        for (int n = 0; n < ITERATIONS; n++) begin
            do begin
                @(posedge clk);
                #1;
            end while (ledStrobe !== 1'b1);
            @(posedge clk);   // Checker samples the strobe cycle first
            #1;
            rnd       = $random(seed);
            switchVal = rnd[15:0];
        end
        repeat (2) @(posedge clk);

        errors = chkErrors;
        if (strobes != ITERATIONS) begin
            $display("Counted %0d LED strobes, %0d expected", strobes, ITERATIONS);
            errors = errors + 1;
        end
        $display("LED strobes: %0d, errors: %0d", strobes, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog sized from the loop length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d of %0d LED strobes",
                     cycles, strobes, ITERATIONS);
            $display("LED strobes: %0d, errors: %0d", strobes, chkErrors + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- mipsCore.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/decodeIf.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memIoStage.sv
rtl/mipsCore.sv
bench/ledChecker.sv
bench/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mipsCore

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/mipsPkg.sv
      - rtl/decodeIf.sv
      - rtl/fetchStage.sv
      - rtl/decodeStage.sv
      - rtl/executeStage.sv
      - rtl/memIoStage.sv
      - rtl/mipsCore.sv
  - target: test
    files:
      - bench/ledChecker.sv
      - bench/mipsCoreTb.sv
